// ==== design/dcache_config.svh ====
// cache geometry and bus tag widths for the data cache; include before the package and any RTL
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// address split, 23 + 6 + 3
`define DC_XLEN         32
`define DC_TAG_BITS     23
`define DC_INDEX_BITS   6
`define DC_OFFSET_BITS  3

// one line is a 64-bit double word
`define DC_LINE_BITS    64
`define DC_LINES        64

// memory transaction tags, tag 0 means no transaction
`define DC_MEM_TAGS     16
`define DC_BUS_TAG_BITS 4

`endif

// ==== design/dcache_pkg.sv ====
// shared types for the data cache: bus and size encodings, processor/memory/response structs
`default_nettype none
`include "dcache_config.svh"

package dcache_pkg;

    // bus command, none when idle
    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_LOAD  = 2'd1,
        BUS_STORE = 2'd2
    } bus_cmd_e;

    typedef enum logic [1:0] {
        MEM_BYTE   = 2'd0,
        MEM_HALF   = 2'd1,
        MEM_WORD   = 2'd2,
        MEM_DOUBLE = 2'd3
    } mem_size_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_MISS = 1'b1 // waiting for memory to accept the line load
    } ctrl_state_e;

    typedef struct packed {
        logic [`DC_XLEN-1:0]      addr;
        logic [`DC_LINE_BITS-1:0] data;    // store data, low bytes used for narrow sizes
        bus_cmd_e                 command;
        mem_size_e                size;
    } proc_req_t;

    typedef struct packed {
        logic [`DC_XLEN-1:0]      addr;
        logic [`DC_LINE_BITS-1:0] data;
        bus_cmd_e                 command;
    } mem_req_t;

    typedef struct packed {
        logic                       hit;
        logic [`DC_LINE_BITS-1:0]   hit_data;
        logic [`DC_BUS_TAG_BITS-1:0] data_tag;      // nonzero when a load refill returns
        logic [`DC_BUS_TAG_BITS-1:0] data_response; // tag handed out for an accepted miss
    } cache_resp_t;

    // one outstanding miss
    typedef struct packed {
        logic                     valid;
        logic [`DC_XLEN-1:0]      addr;
        mem_size_e                size;
        logic [`DC_LINE_BITS-1:0] data;
        logic                     is_store;
    } mshr_entry_t;

    // line coming back from memory
    typedef struct packed {
        logic                        valid;
        logic [`DC_INDEX_BITS-1:0]   index;
        logic [`DC_TAG_BITS-1:0]     tag;
        logic [`DC_LINE_BITS-1:0]    line;     // raw memory data
        logic                        is_store;
        logic [`DC_BUS_TAG_BITS-1:0] mem_tag;
    } refill_t;

endpackage

`default_nettype wire

// ==== design/dcache_lookup.sv ====
// stage 1 of the data cache: splits the address, compares tags and searches in-flight misses
`default_nettype none
`include "dcache_config.svh"

module dcache_lookup (
    input  dcache_pkg::proc_req_t                         req,
    input  logic [`DC_TAG_BITS-1:0]                       line_tag,   // tag at req index
    input  logic                                          line_valid,
    input  logic [`DC_MEM_TAGS-1:0]                       mshr_valid,
    input  logic [`DC_MEM_TAGS-1:0][`DC_XLEN-1:0]         mshr_addr,
    input  logic                                          refill_busy,
    output logic                                          hit,
    output logic                                          store_hit,  // write enable for hit store
    output logic                                          miss,
    output logic                                          in_flight,
    output logic [`DC_INDEX_BITS-1:0]                     index,
    output logic [`DC_TAG_BITS-1:0]                       tag,
    output logic [`DC_OFFSET_BITS-1:0]                    offset
);

    logic access;    // load or store present
    logic tag_match;

    // { tag | index | offset }
    assign tag    = req.addr[`DC_XLEN-1 -: `DC_TAG_BITS];
    assign index  = req.addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign offset = req.addr[`DC_OFFSET_BITS-1:0];

    assign access = (req.command == dcache_pkg::BUS_LOAD) ||
                    (req.command == dcache_pkg::BUS_STORE);
    assign tag_match = line_valid && (line_tag == tag);

    // a returning refill owns the array this cycle
    assign hit       = access && tag_match && !refill_busy;
    assign store_hit = hit && (req.command == dcache_pkg::BUS_STORE);
    assign miss      = access && !tag_match;

    // same line already requested, refuse the duplicate
    always_comb begin
        in_flight = 1'b0;
        for (int i = 0; i < `DC_MEM_TAGS; i++) begin
            if (mshr_valid[i] &&
                mshr_addr[i][`DC_XLEN-1:`DC_OFFSET_BITS] ==
                req.addr[`DC_XLEN-1:`DC_OFFSET_BITS]) begin
                in_flight = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_store_merge.sv ====
// byte-lane merge of store data into a 64-bit line, used for hit stores and refill stores
`default_nettype none
`include "dcache_config.svh"

module dcache_store_merge (
    input  logic [`DC_LINE_BITS-1:0]   line,
    input  logic [`DC_LINE_BITS-1:0]   wdata,  // store data, right aligned
    input  dcache_pkg::mem_size_e      size,
    input  logic [`DC_OFFSET_BITS-1:0] offset, // byte offset in the line, aligned to size
    output logic [`DC_LINE_BITS-1:0]   merged
);

    always_comb begin
        merged = line;
        case (size)
            dcache_pkg::MEM_BYTE: begin
                merged[{offset, 3'b000} +: 8] = wdata[7:0];
            end
            dcache_pkg::MEM_HALF: begin
                merged[{offset[2:1], 4'b0000} +: 16] = wdata[15:0]; // low offset bit ignored
            end
            dcache_pkg::MEM_WORD: begin
                merged[{offset[2], 5'b00000} +: 32] = wdata[31:0];
            end
            default: begin
                merged = wdata; // double covers the whole line
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/dcache_mshr.sv ====
// table of outstanding misses indexed by memory tag; allocates on accept, frees on returning data
`default_nettype none
`include "dcache_config.svh"

module dcache_mshr (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  alloc,       // strobe from controller
    input  logic [`DC_BUS_TAG_BITS-1:0]           alloc_tag,   // tag memory just assigned
    input  dcache_pkg::proc_req_t                 req,
    input  logic [`DC_BUS_TAG_BITS-1:0]           mem_tag,     // nonzero on a return beat
    input  logic [`DC_LINE_BITS-1:0]              mem_data,
    output logic [`DC_MEM_TAGS-1:0]               mshr_valid,
    output logic [`DC_MEM_TAGS-1:0][`DC_XLEN-1:0] mshr_addr,
    output dcache_pkg::refill_t                   refill,
    output dcache_pkg::mshr_entry_t               refill_slot, // size, offset, data for merging
    output logic                                  refill_busy
);

    logic [`DC_MEM_TAGS-1:0]  slot_valid;
    dcache_pkg::mshr_entry_t  slots [`DC_MEM_TAGS]; // payload only
    dcache_pkg::mshr_entry_t  cur;                  // slot named by mem_tag

    always_comb begin
        cur       = slots[mem_tag];
        cur.valid = slot_valid[mem_tag];
    end

    assign refill_busy = (mem_tag != '0) && cur.valid;
    assign refill_slot = cur;
    assign mshr_valid  = slot_valid;

    always_comb begin
        for (int i = 0; i < `DC_MEM_TAGS; i++) begin
            mshr_addr[i] = slots[i].addr;
        end
    end

    // refill descriptor rebuilt from the stored address
    always_comb begin
        refill.valid    = refill_busy;
        refill.index    = cur.addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
        refill.tag      = cur.addr[`DC_XLEN-1 -: `DC_TAG_BITS];
        refill.line     = mem_data;
        refill.is_store = cur.is_store;
        refill.mem_tag  = mem_tag;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot_valid <= '0;
        end else begin
            if (refill_busy) slot_valid[mem_tag] <= 1'b0; // freed on return
            if (alloc)       slot_valid[alloc_tag] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            slots[alloc_tag].addr     <= req.addr;
            slots[alloc_tag].size     <= req.size;
            slots[alloc_tag].data     <= req.data;
            slots[alloc_tag].is_store <= (req.command == dcache_pkg::BUS_STORE);
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_array.sv ====
// data, tag, valid and dirty storage for the 64 lines, with hit-store and refill writes
`default_nettype none
`include "dcache_config.svh"

module dcache_array (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [`DC_INDEX_BITS-1:0]      rd_index,
    input  logic                           st_we,       // hit store
    input  logic [`DC_INDEX_BITS-1:0]      st_index,
    input  logic [`DC_LINE_BITS-1:0]       st_line,     // merged line for the hit store
    input  dcache_pkg::refill_t            refill,
    input  logic [`DC_LINE_BITS-1:0]       refill_line, // refill merged with its store
    output logic [`DC_TAG_BITS-1:0]        line_tag,
    output logic                           line_valid,
    output logic [`DC_LINE_BITS-1:0]       read_line,
    output logic                           evict_valid, // one cycle, write back next
    output logic [`DC_XLEN-1:0]            evict_addr,
    output logic [`DC_LINE_BITS-1:0]       evict_data
);

    logic [`DC_LINE_BITS-1:0] data_mem [`DC_LINES];
    logic [`DC_TAG_BITS-1:0]  tag_mem  [`DC_LINES];
    logic [`DC_LINES-1:0]     valid_q;
    logic [`DC_LINES-1:0]     dirty_q;
    logic                     victim;  // refill lands on a dirty line

    assign line_tag   = tag_mem[rd_index];
    assign line_valid = valid_q[rd_index];
    assign read_line  = data_mem[rd_index];

    assign victim = refill.valid && valid_q[refill.index] && dirty_q[refill.index];

    // control bits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q     <= '0;
            dirty_q     <= '0;
            evict_valid <= 1'b0;
        end else begin
            evict_valid <= victim;
            if (refill.valid) begin
                valid_q[refill.index] <= 1'b1;
                dirty_q[refill.index] <= refill.is_store; // store miss leaves it dirty
            end else if (st_we) begin
                dirty_q[st_index] <= 1'b1;
            end
        end
    end

    // line storage and victim capture
    always_ff @(posedge clk) begin
        if (victim) begin
            evict_addr <= {tag_mem[refill.index], refill.index, {`DC_OFFSET_BITS{1'b0}}};
            evict_data <= data_mem[refill.index]; // old contents before the overwrite
        end
        if (refill.valid) begin
            data_mem[refill.index] <= refill.is_store ? refill_line : refill.line;
            tag_mem[refill.index]  <= refill.tag;
        end else if (st_we) begin
            data_mem[st_index] <= st_line;
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_ctrl.sv ====
// idle/miss controller: picks the memory command, allocates misses and registers the response
`default_nettype none
`include "dcache_config.svh"

module dcache_ctrl (
    input  logic                           clk,
    input  logic                           reset,
    input  dcache_pkg::proc_req_t          req,
    input  logic                           hit,
    input  logic                           miss,
    input  logic                           in_flight,
    input  logic [`DC_LINE_BITS-1:0]       read_line,
    input  dcache_pkg::refill_t            refill,
    input  logic                           evict_valid,
    input  logic [`DC_XLEN-1:0]            evict_addr,
    input  logic [`DC_LINE_BITS-1:0]       evict_data,
    input  logic [`DC_BUS_TAG_BITS-1:0]    mem_response, // 0 = refused, else assigned tag
    output dcache_pkg::mem_req_t           mem_req,
    output logic                           alloc,
    output dcache_pkg::cache_resp_t        resp
);

    dcache_pkg::ctrl_state_e state, next_state;
    dcache_pkg::cache_resp_t next_resp;
    logic                    load_ret; // load refill returning this cycle

    assign load_ret = refill.valid && !refill.is_store;

    // next state and bus command
    always_comb begin
        next_state      = state;
        alloc           = 1'b0;
        mem_req.addr    = '0;
        mem_req.data    = '0;
        mem_req.command = dcache_pkg::BUS_NONE;

        if (evict_valid) begin
            mem_req.addr    = evict_addr; // write-back wins over the miss load
            mem_req.data    = evict_data;
            mem_req.command = dcache_pkg::BUS_STORE;
        end

        case (state)
            dcache_pkg::ST_IDLE: begin
                // in-flight line or pending write-back is refused, response stays 0
                if (miss && !in_flight && !evict_valid) next_state = dcache_pkg::ST_MISS;
            end
            dcache_pkg::ST_MISS: begin
                if (!evict_valid) begin
                    mem_req.addr    = {req.addr[`DC_XLEN-1:`DC_OFFSET_BITS],
                                       {`DC_OFFSET_BITS{1'b0}}};
                    mem_req.command = dcache_pkg::BUS_LOAD; // whole line, store merged on return
                    if (mem_response != '0) begin
                        alloc      = 1'b1;
                        next_state = dcache_pkg::ST_IDLE;
                    end
                end
            end
            default: next_state = dcache_pkg::ST_IDLE;
        endcase
    end

    // response for next cycle
    always_comb begin
        next_resp.hit           = hit;
        next_resp.hit_data      = load_ret ? refill.line : read_line;
        next_resp.data_tag      = load_ret ? refill.mem_tag : '0;
        next_resp.data_response = alloc ? mem_response : '0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= dcache_pkg::ST_IDLE;
            resp  <= '0;
        end else begin
            state <= next_state;
            resp  <= next_resp;
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
// data cache top level wiring lookup, miss table, merges, array and controller between the ports
`default_nettype none
`include "dcache_config.svh"

module dcache_top (
    input  logic                         clk,
    input  logic                         reset,
    input  dcache_pkg::proc_req_t        proc_req,
    output dcache_pkg::cache_resp_t      resp,
    output dcache_pkg::mem_req_t         mem_req,
    input  logic [`DC_BUS_TAG_BITS-1:0]  mem_response,
    input  logic [`DC_LINE_BITS-1:0]     mem_data,
    input  logic [`DC_BUS_TAG_BITS-1:0]  mem_tag
);

    logic                                  hit, store_hit, miss, in_flight;
    logic [`DC_INDEX_BITS-1:0]             index;
    logic [`DC_OFFSET_BITS-1:0]            offset;
    logic [`DC_TAG_BITS-1:0]               line_tag;
    logic                                  line_valid;
    logic [`DC_LINE_BITS-1:0]              read_line, st_line, refill_line;
    logic [`DC_MEM_TAGS-1:0]               mshr_valid;
    logic [`DC_MEM_TAGS-1:0][`DC_XLEN-1:0] mshr_addr;
    logic                                  refill_busy, alloc;
    dcache_pkg::refill_t                   refill;
    dcache_pkg::mshr_entry_t               refill_slot;
    logic                                  evict_valid;
    logic [`DC_XLEN-1:0]                   evict_addr;
    logic [`DC_LINE_BITS-1:0]              evict_data;

    dcache_lookup u_lookup (
        .req(proc_req), .line_tag(line_tag), .line_valid(line_valid),
        .mshr_valid(mshr_valid), .mshr_addr(mshr_addr), .refill_busy(refill_busy),
        .hit(hit), .store_hit(store_hit), .miss(miss), .in_flight(in_flight),
        .index(index), .tag(), .offset(offset)
    );

    // alloc tag comes straight from the memory response
    dcache_mshr u_mshr (
        .clk(clk), .reset(reset), .alloc(alloc), .alloc_tag(mem_response), .req(proc_req),
        .mem_tag(mem_tag), .mem_data(mem_data), .mshr_valid(mshr_valid),
        .mshr_addr(mshr_addr), .refill(refill), .refill_slot(refill_slot),
        .refill_busy(refill_busy)
    );

    dcache_store_merge u_hit_merge (
        .line(read_line), .wdata(proc_req.data), .size(proc_req.size), .offset(offset),
        .merged(st_line)
    );

    // store miss data folded into the returning line
    dcache_store_merge u_refill_merge (
        .line(refill.line), .wdata(refill_slot.data), .size(refill_slot.size),
        .offset(refill_slot.addr[`DC_OFFSET_BITS-1:0]), .merged(refill_line)
    );

    dcache_array u_array (
        .clk(clk), .reset(reset), .rd_index(index), .st_we(store_hit), .st_index(index),
        .st_line(st_line), .refill(refill), .refill_line(refill_line),
        .line_tag(line_tag), .line_valid(line_valid), .read_line(read_line),
        .evict_valid(evict_valid), .evict_addr(evict_addr), .evict_data(evict_data)
    );

    dcache_ctrl u_ctrl (
        .clk(clk), .reset(reset), .req(proc_req), .hit(hit), .miss(miss),
        .in_flight(in_flight), .read_line(read_line), .refill(refill),
        .evict_valid(evict_valid), .evict_addr(evict_addr), .evict_data(evict_data),
        .mem_response(mem_response), .mem_req(mem_req), .alloc(alloc), .resp(resp)
    );

endmodule

`default_nettype wire

// ==== sim/mem_model.sv ====
// tagged memory model for the cache testbench: random accept, random return latency, write-back log
`default_nettype none

module mem_model (
    input  logic                 clk,
    input  logic                 reset,
    input  dcache_pkg::mem_req_t mem_req,
    output logic [3:0]           mem_response, // 0 refused, else tag for this load
    output logic [63:0]          mem_data,
    output logic [3:0]           mem_tag,      // nonzero for one return beat
    output int                   wb_count,
    output logic [31:0]          last_wb_addr
);

    logic [63:0] store_mem [logic [28:0]]; // sparse, keyed by line number
    logic [15:0] busy;                     // tags still owned by a load
    logic [15:0] busy_n;
    logic [3:0]  rr;                       // last tag handed out
    logic        accept;
    logic        grant_ok;
    logic [3:0]  grant_tag;
    logic [31:0] line_addr [16];
    int          due [16];                 // cycles left before the beat
    logic [3:0]  ret_q;
    logic [3:0]  ret_n;
    logic [63:0] ret_data_q;
    int          cand;
    int          seed = 56251;

    function automatic logic [63:0] fill_line(input logic [31:0] a);
        return {a ^ 32'h9e37_79b9, ~a}; // a is a line address
    endfunction

    function automatic logic [63:0] read_line(input logic [31:0] a);
        if (store_mem.exists(a[31:3])) begin
            return store_mem[a[31:3]];
        end
        return fill_line({a[31:3], 3'b000});
    endfunction

    // round robin from the last tag, tag 0 never used
    always_comb begin
        grant_ok  = 1'b0;
        grant_tag = '0;
        for (int k = 0; k < 15; k++) begin
            cand = ((int'(rr) + k) % 15) + 1;
            if (!grant_ok && !busy[cand]) begin
                grant_ok  = 1'b1;
                grant_tag = cand[3:0];
            end
        end
        mem_response = (mem_req.command == dcache_pkg::BUS_LOAD && accept && grant_ok) ?
                       grant_tag : '0;
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= '0;
            rr       <= '0;
            ret_q    <= '0;
            wb_count <= 0;
        end else begin
            busy_n = busy;
            if (ret_q != '0) busy_n[ret_q] = 1'b0; // beat went out last cycle
            if (mem_req.command == dcache_pkg::BUS_STORE) begin
                store_mem[mem_req.addr[31:3]] = mem_req.data; // write-back lands at once
                wb_count     <= wb_count + 1;
                last_wb_addr <= mem_req.addr;
            end
            ret_n = '0;
            for (int t = 1; t < 16; t++) begin
                if (busy[t] && t != ret_q) begin
                    if (due[t] > 0) due[t] = due[t] - 1;
                    else if (ret_n == '0) ret_n = t[3:0];
                end
            end
            if (mem_response != '0) begin
                busy_n[mem_response]    = 1'b1;
                line_addr[mem_response] = mem_req.addr;
                due[mem_response]       = 2 + ($unsigned($random(seed)) % 7);
                rr <= mem_response;
            end
            ret_data_q <= read_line(line_addr[ret_n]);
            ret_q      <= ret_n;
            busy       <= busy_n;
        end
    end

    initial begin
        mem_tag  = '0;
        mem_data = '0;
        accept   = 1'b0;
    end

    // outputs move a little after the edge
    always @(posedge clk) begin
        #1;
        mem_tag  = ret_q;
        mem_data = (ret_q != '0) ? ret_data_q : '0;
        accept   = ($unsigned($random(seed)) % 4) != 0; // about one in four refused
    end

endmodule

`default_nettype wire

// ==== sim/tb_dcache.sv ====
// testbench for the data cache driving processor requests against the memory model and golden bytes
`default_nettype none

module tb_dcache;

    logic                    clk;
    logic                    reset;
    dcache_pkg::proc_req_t   proc_req;
    dcache_pkg::cache_resp_t resp;
    dcache_pkg::mem_req_t    mem_req;
    logic [3:0]              mem_response;
    logic [3:0]              mem_tag;
    logic [63:0]             mem_data;
    int                      wb_count;
    logic [31:0]             last_wb_addr;

    logic [7:0]  gold [logic [31:0]]; // bytes written so far in program order
    logic [63:0] pend_line [16];      // expected refill per load tag
    logic [15:0] pend_valid;
    int          last_wait;           // cycles refused before the last response
    int          seed = 56251;

    dcache_top u_dcache_top (
        .clk(clk), .reset(reset), .proc_req(proc_req), .resp(resp), .mem_req(mem_req),
        .mem_response(mem_response), .mem_data(mem_data), .mem_tag(mem_tag)
    );

    mem_model u_mem_model (
        .clk(clk), .reset(reset), .mem_req(mem_req), .mem_response(mem_response),
        .mem_data(mem_data), .mem_tag(mem_tag), .wb_count(wb_count),
        .last_wb_addr(last_wb_addr)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] make_addr(input int tag, input int idx, input int off);
        return {tag[22:0], idx[5:0], off[2:0]};
    endfunction

    function automatic logic [63:0] fill_line(input logic [31:0] a);
        return {a ^ 32'h9e37_79b9, ~a};
    endfunction

    // expected line from stored bytes over the fill pattern
    function automatic logic [63:0] ref_line(input logic [31:0] addr);
        logic [31:0] base;
        logic [63:0] line;
        base = {addr[31:3], 3'b000};
        line = fill_line(base);
        for (int i = 0; i < 8; i++) begin
            if (gold.exists(base + i)) line[8*i +: 8] = gold[base + i];
        end
        return line;
    endfunction

    function automatic void apply_store(input logic [31:0] addr, input logic [1:0] size,
                                        input logic [63:0] data);
        for (int i = 0; i < (1 << size); i++) begin
            gold[addr + i] = data[8*i +: 8]; // little endian lanes
        end
    endfunction

    task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic fail_msg(input string msg);
        $display("%0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_quiet();
        assert (mem_req.command == dcache_pkg::BUS_NONE)
            else fail_value("mem_req.command", mem_req.command, dcache_pkg::BUS_NONE);
        assert (resp.hit == 1'b0) else fail_value("resp.hit", resp.hit, 0);
        assert (resp.data_tag == '0) else fail_value("resp.data_tag", resp.data_tag, 0);
        assert (resp.data_response == '0)
            else fail_value("resp.data_response", resp.data_response, 0);
    endtask

    // hold one request until hit or an accepted miss
    task automatic access(input dcache_pkg::bus_cmd_e cmd, input logic [31:0] addr,
                          input dcache_pkg::mem_size_e size, input logic [63:0] data,
                          input bit expect_refuse, output bit was_hit);
        int         waited;
        bit         done;
        logic [3:0] t;
        waited = 0;
        done   = 0;
        @(posedge clk);
        #1;
        proc_req.addr    = addr;
        proc_req.data    = data;
        proc_req.size    = size;
        proc_req.command = cmd;
        while (!done) begin
            @(posedge clk);
            #1;
            if (resp.hit) begin
                done    = 1;
                was_hit = 1;
                if (cmd == dcache_pkg::BUS_LOAD) begin
                    assert (resp.hit_data == ref_line(addr))
                        else fail_value("resp.hit_data", resp.hit_data, ref_line(addr));
                end else begin
                    apply_store(addr, size, data);
                end
            end else if (resp.data_response != '0) begin
                done    = 1;
                was_hit = 0;
                t       = resp.data_response;
                assert (!expect_refuse) else fail_msg("a miss to a line in flight was accepted");
                if (cmd == dcache_pkg::BUS_LOAD) begin
                    assert (!pend_valid[t]) else fail_msg("a memory tag was handed out twice");
                    pend_line[t]  = ref_line(addr);
                    pend_valid[t] = 1'b1;
                end else begin
                    apply_store(addr, size, data); // merged on refill
                end
            end else begin
                waited++;
                if (waited > 300) fail_msg("timeout waiting for a cache response");
            end
        end
        last_wait        = waited;
        proc_req.command = dcache_pkg::BUS_NONE;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pend_valid != '0) begin
            @(posedge clk);
            waited++;
            if (waited > 300) fail_msg("timeout waiting for outstanding load refills");
        end
    endtask

    // refill returns and write-backs
    always @(posedge clk) begin
        #2;
        if (!reset && resp.data_tag != '0) begin
            assert (pend_valid[resp.data_tag]) else fail_msg("refill data for a tag not pending");
            assert (resp.hit_data == pend_line[resp.data_tag])
                else fail_value("resp.hit_data", resp.hit_data, pend_line[resp.data_tag]);
            pend_valid[resp.data_tag] = 1'b0;
        end
        #3;
        if (!reset && mem_req.command == dcache_pkg::BUS_STORE) begin
            assert (mem_req.data == ref_line(mem_req.addr))
                else fail_value("mem_req.data", mem_req.data, ref_line(mem_req.addr));
        end
    end

    initial begin
        bit          h;
        int          wb_before;
        int          waited;
        int          sz;
        int          off;
        logic [63:0] d;
        clk        = 1'b0;
        reset      = 1'b1;
        proc_req   = '0;
        pend_valid = '0;
        last_wait  = 0;
        repeat (4) begin
            @(posedge clk);
            #1;
            check_quiet();
        end
        reset = 1'b0;
        @(posedge clk);
        #1;
        check_quiet();

        // load miss followed by a hit on the same line
        access(dcache_pkg::BUS_LOAD, make_addr(1, 5, 0), dcache_pkg::MEM_DOUBLE, '0, 0, h);
        assert (!h) else fail_msg("first load of a line did not miss");
        wait_drain();
        access(dcache_pkg::BUS_LOAD, make_addr(1, 5, 0), dcache_pkg::MEM_DOUBLE, '0, 0, h);
        assert (h) else fail_msg("load of a refilled line did not hit");
        assert (last_wait == 0) else fail_msg("load hit did not answer in the next cycle");

        // every size at every aligned offset
        for (sz = 0; sz < 4; sz++) begin
            for (off = 0; off < 8; off += (1 << sz)) begin
                d = {$random(seed), $random(seed)};
                access(dcache_pkg::BUS_STORE, make_addr(1, 5, off),
                       dcache_pkg::mem_size_e'(sz), d, 0, h);
                assert (h) else fail_msg("store to a cached line did not hit");
                access(dcache_pkg::BUS_LOAD, make_addr(1, 5, 0), dcache_pkg::MEM_DOUBLE,
                       '0, 0, h);
                assert (h) else fail_msg("load after a store hit did not hit");
            end
        end

        // store miss with the line refused while in flight
        access(dcache_pkg::BUS_STORE, make_addr(2, 9, 4), dcache_pkg::MEM_WORD,
               64'h1234_5678, 0, h);
        assert (!h) else fail_msg("store to an absent line did not miss");
        access(dcache_pkg::BUS_LOAD, make_addr(2, 9, 0), dcache_pkg::MEM_DOUBLE, '0, 1, h);

        // dirty line at index 5 evicted by another tag
        wb_before = wb_count;
        access(dcache_pkg::BUS_LOAD, make_addr(3, 5, 0), dcache_pkg::MEM_DOUBLE, '0, 0, h);
        wait_drain();
        waited = 0;
        while (wb_count == wb_before) begin
            @(posedge clk);
            waited++;
            if (waited > 100) fail_msg("timeout waiting for the write-back of a dirty line");
        end
        assert (last_wb_addr == make_addr(1, 5, 0))
            else fail_value("mem_req.addr", last_wb_addr, make_addr(1, 5, 0));
        access(dcache_pkg::BUS_LOAD, make_addr(1, 5, 0), dcache_pkg::MEM_DOUBLE, '0, 0, h);
        wait_drain();

        // mixed traffic over a few lines that share indices
        repeat (400) begin
            sz  = $unsigned($random(seed)) % 4;
            off = ($unsigned($random(seed)) % 8) & ~((1 << sz) - 1);
            d   = {$random(seed), $random(seed)};
            access(($unsigned($random(seed)) % 2) ? dcache_pkg::BUS_LOAD : dcache_pkg::BUS_STORE,
                   make_addr(1 + $unsigned($random(seed)) % 3, $unsigned($random(seed)) % 4, off),
                   dcache_pkg::mem_size_e'(sz), d, 0, h);
        end
        wait_drain();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/dcache_pkg.sv
design/dcache_lookup.sv
design/dcache_store_merge.sv
design/dcache_mshr.sv
design/dcache_array.sv
design/dcache_ctrl.sv
design/dcache_top.sv
sim/mem_model.sv
sim/tb_dcache.sv

// ==== Makefile ====
# verilator build and run of the data cache testbench

all: run

run: obj_dir/tb_dcache
	@out="$$(./obj_dir/tb_dcache)"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

obj_dir/tb_dcache: sim.f design/*.sv design/*.svh sim/*.sv
	verilator --binary --timing --assert -f sim.f --top-module tb_dcache -o tb_dcache

lint:
	verilator --lint-only --timing -f sim.f --top-module dcache_top

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
